// ==== src/exec_pkg.sv ====
package exec_pkg;

    // datapath width
    localparam int XLEN    = 32;
    localparam int SHAMT_W = 5;   // shift amount, low bits of operand b

    typedef logic [XLEN-1:0] word_t;       // pc, operands, results, targets
    typedef logic [3:0]      alu_op_t;
    typedef logic [2:0]      funct3_t;     // branch condition
    typedef logic [1:0]      result_sel_t;

    // ----------------------------------------------------------------------
    // alu operation codes
    // ----------------------------------------------------------------------
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLL  = 4'd2;
    localparam alu_op_t ALU_SLT  = 4'd3;
    localparam alu_op_t ALU_SLTU = 4'd4;
    localparam alu_op_t ALU_XOR  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_OR   = 4'd8;
    localparam alu_op_t ALU_AND  = 4'd9;

    // branch conditions, same encoding as funct3 of B-type
    localparam funct3_t BR_EQ  = 3'd0;
    localparam funct3_t BR_NE  = 3'd1;
    localparam funct3_t BR_LT  = 3'd4;
    localparam funct3_t BR_GE  = 3'd5;
    localparam funct3_t BR_LTU = 3'd6;
    localparam funct3_t BR_GEU = 3'd7;

    // write-back select, code 1 falls back to the alu result
    localparam result_sel_t RES_ALU = 2'd0;
    localparam result_sel_t RES_PC4 = 2'd2;
    localparam result_sel_t RES_IMM = 2'd3;

    // two-bit saturating predictor, msb is the prediction
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } bp_state_t;

endpackage

// ==== src/exec_if.sv ====
`timescale 1ns/1ps

// ----------------------------------------------------------------------
// issue side: one decoded instruction with its operands
// ----------------------------------------------------------------------
interface issue_if;
    import exec_pkg::*;

    logic        in_valid;
    word_t       pc;
    word_t       rs1_val;
    word_t       rs2_val;
    word_t       imm;
    alu_op_t     alu_op;
    logic        use_rs2;      // rs2 instead of imm as operand b
    result_sel_t result_sel;
    logic        is_branch;
    logic        is_jump;
    logic        is_jalr;
    funct3_t     cond;
    logic        pred_taken;   // what fetch guessed

    modport consumer (
        input in_valid, pc, rs1_val, rs2_val, imm, alu_op, use_rs2,
        input result_sel, is_branch, is_jump, is_jalr, cond, pred_taken
    );
endinterface

// ----------------------------------------------------------------------
// stage-1 results, written by alu_unit and branch_unit
// ----------------------------------------------------------------------
interface resolve_if;
    import exec_pkg::*;

    logic  valid;
    word_t wb_value;
    logic  taken;
    word_t target;
    word_t pc_plus4;
    logic  was_branch;
    logic  was_pred;

    modport alu      (output valid, wb_value);
    modport branch   (output taken, target, pc_plus4, was_branch, was_pred);
    modport consumer (input valid, wb_value, taken, target, pc_plus4, was_branch, was_pred);
endinterface

// ==== src/alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit (
    input  logic       clk,
    input  logic       rst,
    issue_if.consumer  iss,
    resolve_if.alu     res
);
    import exec_pkg::*;

    word_t               op_a;
    word_t               op_b;
    logic [SHAMT_W-1:0]  shamt;
    logic                lt_s;
    logic                lt_u;
    word_t               alu_res;
    word_t               wb_c;

    // ----------------------------------------------------------------------
    // operand selection
    // ----------------------------------------------------------------------
    assign op_a  = iss.rs1_val;
    assign op_b  = iss.use_rs2 ? iss.rs2_val : iss.imm;
    assign shamt = op_b[SHAMT_W-1:0];

    assign lt_s = $signed(op_a) < $signed(op_b);
    assign lt_u = op_a < op_b;

    always_comb begin
        case (iss.alu_op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << shamt;
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, lt_u};
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> shamt;
            ALU_SRA:  alu_res = word_t'($signed(op_a) >>> shamt);  // keeps sign
            ALU_OR:   alu_res = op_a | op_b;
            ALU_AND:  alu_res = op_a & op_b;
            default:  alu_res = '0;   // undefined op
        endcase
    end

    // write-back value select
    always_comb begin
        case (iss.result_sel)
            RES_PC4: wb_c = iss.pc + word_t'(4);   // link address for jal/jalr
            RES_IMM: wb_c = iss.imm;               // lui
            default: wb_c = alu_res;
        endcase
    end

    // ----------------------------------------------------------------------
    // stage register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= iss.in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (iss.in_valid) begin
            res.wb_value <= wb_c;
        end
    end

endmodule

// ==== src/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
    input  logic       clk,
    input  logic       rst,
    issue_if.consumer  iss,
    resolve_if.branch  res
);
    import exec_pkg::*;

    logic  eq;
    logic  lt_s;
    logic  lt_u;
    logic  cond_ok;
    logic  taken_c;
    word_t target_c;

    // compare the two register operands
    assign eq   = iss.rs1_val == iss.rs2_val;
    assign lt_s = $signed(iss.rs1_val) < $signed(iss.rs2_val);
    assign lt_u = iss.rs1_val < iss.rs2_val;

    always_comb begin
        case (iss.cond)
            BR_EQ:   cond_ok = eq;
            BR_NE:   cond_ok = !eq;
            BR_LT:   cond_ok = lt_s;
            BR_GE:   cond_ok = !lt_s;
            BR_LTU:  cond_ok = lt_u;
            BR_GEU:  cond_ok = !lt_u;
            default: cond_ok = 1'b0;   // codes 2, 3 never taken
        endcase
    end

    // jumps always taken, branches when the condition holds
    assign taken_c  = iss.is_jump | iss.is_jalr | (iss.is_branch & cond_ok);
    assign target_c = iss.is_jalr ? iss.rs1_val + iss.imm : iss.pc + iss.imm;

    // ----------------------------------------------------------------------
    // stage register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res.taken      <= 1'b0;
            res.was_branch <= 1'b0;
            res.was_pred   <= 1'b0;
        end else begin
            res.taken <= iss.in_valid & taken_c;   // cleared on idle cycles
            if (iss.in_valid) begin
                res.was_branch <= iss.is_branch;
                res.was_pred   <= iss.pred_taken;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (iss.in_valid) begin
            res.target   <= target_c;
            res.pc_plus4 <= iss.pc + word_t'(4);  // fall-through
        end
    end

endmodule

// ==== src/redirect_ctrl.sv ====
`timescale 1ns/1ps

module redirect_ctrl (
    input  logic              clk,
    input  logic              rst,
    resolve_if.consumer       res,
    output logic              out_valid,
    output exec_pkg::word_t   wb_value,
    output logic              redirect,
    output exec_pkg::word_t   redirect_pc,
    output logic              predict_taken
);
    import exec_pkg::*;

    logic      wrong;        // prediction differs from outcome
    logic      mispredict;
    bp_state_t state;
    bp_state_t state_nxt;

    assign wrong      = res.was_pred ^ res.taken;
    assign mispredict = res.valid & wrong;

    // ----------------------------------------------------------------------
    // output register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            redirect  <= 1'b0;
        end else begin
            out_valid <= res.valid;
            redirect  <= mispredict;
        end
    end

    always_ff @(posedge clk) begin
        if (res.valid) begin
            wb_value <= res.wb_value;
            // guessed not taken but taken -> target, else back to pc+4
            redirect_pc <= res.taken ? res.target : res.pc_plus4;
        end
    end

    // ----------------------------------------------------------------------
    // two-bit predictor, steps on every resolved branch
    // ----------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            STRONG_NT: begin
                state_nxt = wrong ? WEAK_NT : STRONG_NT;
            end
            WEAK_NT: begin
                state_nxt = wrong ? WEAK_T : STRONG_NT;
            end
            WEAK_T: begin
                state_nxt = wrong ? WEAK_NT : STRONG_T;
            end
            STRONG_T: begin
                state_nxt = wrong ? WEAK_T : STRONG_T;
            end
            default: begin
                state_nxt = STRONG_NT;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= STRONG_NT;
        end else if (res.valid && res.was_branch) begin  // jumps leave it alone
            state <= state_nxt;
        end
    end

    assign predict_taken = state[1];   // weak or strong taken

endmodule

// ==== src/riscv_exec.sv ====
`timescale 1ns/1ps

module riscv_exec (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  exec_pkg::word_t        pc,
    input  exec_pkg::word_t        rs1_val,
    input  exec_pkg::word_t        rs2_val,
    input  exec_pkg::word_t        imm,
    input  exec_pkg::alu_op_t      alu_op,
    input  logic                   use_rs2,
    input  exec_pkg::result_sel_t  result_sel,
    input  logic                   is_branch,
    input  logic                   is_jump,
    input  logic                   is_jalr,
    input  exec_pkg::funct3_t      cond,
    input  logic                   pred_taken,
    output logic                   out_valid,
    output exec_pkg::word_t        wb_value,
    output logic                   redirect,
    output exec_pkg::word_t        redirect_pc,
    output logic                   predict_taken
);

    issue_if   u_iss ();
    resolve_if u_res ();

    // ----------------------------------------------------------------------
    // issue bundle from the plain ports
    // ----------------------------------------------------------------------
    assign u_iss.in_valid   = in_valid;
    assign u_iss.pc         = pc;
    assign u_iss.rs1_val    = rs1_val;
    assign u_iss.rs2_val    = rs2_val;
    assign u_iss.imm        = imm;
    assign u_iss.alu_op     = alu_op;
    assign u_iss.use_rs2    = use_rs2;
    assign u_iss.result_sel = result_sel;
    assign u_iss.is_branch  = is_branch;
    assign u_iss.is_jump    = is_jump;
    assign u_iss.is_jalr    = is_jalr;
    assign u_iss.cond       = cond;
    assign u_iss.pred_taken = pred_taken;

    // stage 1, both units see the same instruction
    alu_unit u_alu_unit (
        .clk (clk),
        .rst (rst),
        .iss (u_iss),
        .res (u_res)
    );

    branch_unit u_branch_unit (
        .clk (clk),
        .rst (rst),
        .iss (u_iss),
        .res (u_res)
    );

    // stage 2 and predictor
    redirect_ctrl u_redirect_ctrl (
        .clk           (clk),
        .rst           (rst),
        .res           (u_res),
        .out_valid     (out_valid),
        .wb_value      (wb_value),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .predict_taken (predict_taken)
    );

endmodule

// ==== testbench/riscv_exec_asserts.sv ====
`timescale 1ns/1ps

module riscv_exec_asserts (
    input logic clk,
    input logic rst,
    input logic in_valid,
    input logic out_valid,
    input logic redirect,
    input logic predict_taken
);

    int fail_cnt = 0;   // failed assertions so far

    // ----------------------------------------------------------------------
    // output protocol
    // ----------------------------------------------------------------------
    a_redirect_needs_valid: assert property (
        @(posedge clk) disable iff (rst) redirect |-> out_valid
    ) else begin
        fail_cnt++;
        $error("redirect raised without out_valid");
    end

    a_valid_latency: assert property (
        @(posedge clk) disable iff (rst) in_valid |-> ##2 out_valid
    ) else begin
        fail_cnt++;
        $error("accepted instruction did not come out two cycles later");
    end

    a_no_spurious_valid: assert property (
        @(posedge clk) disable iff (rst) out_valid |-> $past(in_valid, 2)
    ) else begin
        fail_cnt++;
        $error("out_valid without an instruction two cycles earlier");
    end

    // everything quiet while reset is held
    a_reset_quiet: assert property (
        @(posedge clk) rst |-> !out_valid && !redirect && !predict_taken
    ) else begin
        fail_cnt++;
        $error("outputs not low during reset");
    end

endmodule

// ==== testbench/tb_riscv_exec.sv ====
`timescale 1ns/1ps

module tb_riscv_exec;
    import exec_pkg::*;

    logic        clk = 1'b0;
    logic        rst;
    logic        in_valid;
    word_t       pc, rs1_val, rs2_val, imm;
    alu_op_t     alu_op;
    logic        use_rs2;
    result_sel_t result_sel;
    logic        is_branch, is_jump, is_jalr;
    funct3_t     cond;
    logic        pred_taken;
    logic        out_valid;
    word_t       wb_value;
    logic        redirect;
    word_t       redirect_pc;
    logic        predict_taken;

    integer      seed = 32'h40bb;
    int          errors = 0;
    int          timeouts = 0;
    int          checks = 0;
    bp_state_t   model_st = STRONG_NT;   // mirror of the predictor

    // expected results with the oldest first
    string       name_q[$];
    word_t       wb_q[$];
    logic        redir_q[$];
    word_t       rpc_q[$];
    logic        pt_q[$];

    always #2 clk = ~clk;

    riscv_exec u_riscv_exec (
        .clk (clk), .rst (rst), .in_valid (in_valid), .pc (pc),
        .rs1_val (rs1_val), .rs2_val (rs2_val), .imm (imm), .alu_op (alu_op),
        .use_rs2 (use_rs2), .result_sel (result_sel), .is_branch (is_branch),
        .is_jump (is_jump), .is_jalr (is_jalr), .cond (cond), .pred_taken (pred_taken),
        .out_valid (out_valid), .wb_value (wb_value), .redirect (redirect),
        .redirect_pc (redirect_pc), .predict_taken (predict_taken)
    );

    bind riscv_exec riscv_exec_asserts u_riscv_exec_asserts (
        .clk (clk), .rst (rst), .in_valid (in_valid), .out_valid (out_valid),
        .redirect (redirect), .predict_taken (predict_taken)
    );

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------
    function automatic word_t alu_expected(input word_t a, input word_t b, input alu_op_t op);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 32'd1;
            ALU_SLL:  return a << sh;
            ALU_SLT:  return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
            ALU_SLTU: return {31'b0, a < b};
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            default:  return 32'h0;
        endcase
    endfunction

    function automatic logic cond_holds(input word_t a, input word_t b, input funct3_t c);
        logic lt_u;
        logic lt_s;
        lt_u = a < b;
        lt_s = (a[31] != b[31]) ? a[31] : lt_u;   // with differing signs the negative one is less
        case (c)
            BR_EQ:   return a == b;
            BR_NE:   return a != b;
            BR_LT:   return lt_s;
            BR_GE:   return !lt_s;
            BR_LTU:  return lt_u;
            BR_GEU:  return !lt_u;
            default: return 1'b0;
        endcase
    endfunction

    function automatic bp_state_t next_bp(input bp_state_t st, input logic wrong);
        case (st)
            STRONG_NT: return wrong ? WEAK_NT : STRONG_NT;
            WEAK_NT:   return wrong ? WEAK_T : STRONG_NT;
            WEAK_T:    return wrong ? WEAK_NT : STRONG_T;
            default:   return wrong ? WEAK_T : STRONG_T;
        endcase
    endfunction

    function automatic void compute_expected(
        input word_t pc_i, rs1_i, rs2_i, imm_i, input alu_op_t op_i, input logic use_rs2_i,
        input result_sel_t sel_i, input logic br_i, jal_i, jalr_i, input funct3_t cond_i,
        input logic pred_i, inout bp_state_t st,
        output word_t wb, output logic rd, output word_t rpc, output logic pt
    );
        logic taken;
        case (sel_i)
            RES_PC4: wb = pc_i + 32'd4;
            RES_IMM: wb = imm_i;
            default: wb = alu_expected(rs1_i, use_rs2_i ? rs2_i : imm_i, op_i);
        endcase
        taken = jal_i | jalr_i | (br_i & cond_holds(rs1_i, rs2_i, cond_i));
        rd    = pred_i ^ taken;
        rpc   = !taken ? pc_i + 32'd4 : (jalr_i ? rs1_i + imm_i : pc_i + imm_i);
        if (br_i) begin
            st = next_bp(st, rd);
        end
        pt = st[1];
    endfunction

    // ----------------------------------------------------------------------
    // stimulus helpers
    // ----------------------------------------------------------------------
    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    task automatic send_instr(
        input string name, input word_t pc_i, rs1_i, rs2_i, imm_i, input alu_op_t op_i,
        input logic use_rs2_i, input result_sel_t sel_i, input logic br_i, jal_i, jalr_i,
        input funct3_t cond_i, input logic pred_i
    );
        word_t e_wb;
        logic  e_rd;
        word_t e_rpc;
        logic  e_pt;
        compute_expected(pc_i, rs1_i, rs2_i, imm_i, op_i, use_rs2_i, sel_i, br_i, jal_i,
                         jalr_i, cond_i, pred_i, model_st, e_wb, e_rd, e_rpc, e_pt);
        name_q.push_back(name);
        wb_q.push_back(e_wb);
        redir_q.push_back(e_rd);
        rpc_q.push_back(e_rpc);
        pt_q.push_back(e_pt);
        @(posedge clk);
        in_valid   <= 1'b1;
        pc         <= pc_i;
        rs1_val    <= rs1_i;
        rs2_val    <= rs2_i;
        imm        <= imm_i;
        alu_op     <= op_i;
        use_rs2    <= use_rs2_i;
        result_sel <= sel_i;
        is_branch  <= br_i;
        is_jump    <= jal_i;
        is_jalr    <= jalr_i;
        cond       <= cond_i;
        pred_taken <= pred_i;
    endtask

    task automatic wait_drained(input string tag);
        int cnt;
        @(posedge clk);
        in_valid <= 1'b0;
        cnt = 0;
        while (name_q.size() != 0 && cnt < 20) begin
            @(posedge clk);
            cnt++;
        end
        if (name_q.size() != 0) begin
            timeouts++;
            $display("timeout in %s, %0d results never came out", tag, name_q.size());
            name_q.delete();
            wb_q.delete();
            redir_q.delete();
            rpc_q.delete();
            pt_q.delete();
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        model_st = STRONG_NT;
    endtask

    // ----------------------------------------------------------------------
    // scoreboard on the falling edge where outputs are stable
    // ----------------------------------------------------------------------
    always @(negedge clk) begin : scoreboard
        string n;
        word_t e_wb;
        logic  e_rd;
        word_t e_rpc;
        logic  e_pt;
        if (!rst && out_valid === 1'b1) begin
            if (name_q.size() == 0) begin
                errors++;
                $display("out_valid went high with no instruction outstanding");
            end else begin
                n     = name_q.pop_front();
                e_wb  = wb_q.pop_front();
                e_rd  = redir_q.pop_front();
                e_rpc = rpc_q.pop_front();
                e_pt  = pt_q.pop_front();
                checks++;
                assert (wb_value === e_wb) else begin
                    errors++;
                    $display("CHECK FAILED %s wb_value expected %h actual %h", n, e_wb, wb_value);
                end
                assert (redirect === e_rd) else begin
                    errors++;
                    $display("CHECK FAILED %s redirect expected %b actual %b", n, e_rd, redirect);
                end
                if (e_rd) begin
                    assert (redirect_pc === e_rpc) else begin
                        errors++;
                        $display("CHECK FAILED %s redirect_pc expected %h actual %h",
                                 n, e_rpc, redirect_pc);
                    end
                end
                assert (predict_taken === e_pt) else begin
                    errors++;
                    $display("CHECK FAILED %s predict_taken expected %b actual %b",
                             n, e_pt, predict_taken);
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------
    initial begin : stimulus
        word_t a;
        word_t b;
        int    kind;
        rst = 1'b0;
        in_valid = 1'b0;
        pc = '0;
        rs1_val = '0;
        rs2_val = '0;
        imm = '0;
        alu_op = ALU_ADD;
        use_rs2 = 1'b0;
        result_sel = RES_ALU;
        is_branch = 1'b0;
        is_jump = 1'b0;
        is_jalr = 1'b0;
        cond = BR_EQ;
        pred_taken = 1'b0;
        apply_reset();

        // every op code including the undefined 10 and 11
        for (int op = 0; op < 12; op++) begin
            for (int k = 0; k < 6; k++) begin
                send_instr($sformatf("alu op %0d", op), rand_word() & 32'hffff_fffc,
                           rand_word(), rand_word(), rand_word(), alu_op_t'(op), k[0],
                           RES_ALU, 1'b0, 1'b0, 1'b0, BR_EQ, 1'b0);
            end
        end
        for (int k = 0; k < 12; k++) begin
            send_instr($sformatf("result sel %0d", k % 3 + 1), rand_word() & 32'hffff_fffc,
                       rand_word(), rand_word(), rand_word(), ALU_XOR, 1'b1,
                       result_sel_t'(k % 3 + 1), 1'b0, 1'b0, 1'b0, BR_EQ, 1'b0);
        end
        wait_drained("alu and result select");

        // equal, signed-negative and unsigned-large pairs
        for (int c = 0; c < 8; c++) begin
            for (int p = 0; p < 6; p++) begin
                a = rand_word();
                b = (p / 2 == 0) ? a : rand_word();
                if (p / 2 == 1) begin
                    a = a | 32'h8000_0000;
                    b = b & 32'h7fff_ffff;
                end else if (p / 2 == 2) begin
                    a = a & 32'h7fff_ffff;
                    b = b | 32'h8000_0000;
                end
                if (c != 2 && c != 3) begin
                    send_instr($sformatf("branch cond %0d pair %0d", c, p), 32'h0000_1000,
                               a, b, 32'h0000_0040, ALU_ADD, 1'b1, RES_ALU, 1'b1, 1'b0,
                               1'b0, funct3_t'(c), p[0]);
                end
            end
        end
        wait_drained("branch conditions");

        for (int k = 0; k < 4; k++) begin
            send_instr($sformatf("jump %0d", k), 32'h0000_2000, rand_word(), rand_word(),
                       rand_word() & 32'h0000_fffe, ALU_ADD, 1'b0, RES_PC4, 1'b0,
                       !k[1], k[1], BR_EQ, k[0]);
        end
        wait_drained("jumps");

        // predictor from reset with fetch following the counter
        apply_reset();
        @(negedge clk);
        assert (predict_taken === 1'b0) else begin
            errors++;
            $display("CHECK FAILED reset predict_taken expected 0 actual %b", predict_taken);
        end
        for (int k = 0; k < 8; k++) begin
            a = rand_word();
            send_instr($sformatf("predictor step %0d", k), 32'h0000_3000, a,
                       (k < 4) ? a : a + 32'd1, 32'h0000_0010, ALU_ADD, 1'b1, RES_ALU,
                       1'b1, 1'b0, 1'b0, BR_EQ, model_st[1]);
        end
        wait_drained("predictor");

        for (int k = 0; k < 40; k++) begin
            kind = $random(seed) & 3;
            send_instr($sformatf("stream %0d", k), rand_word() & 32'hffff_fffc, rand_word(),
                       (kind == 1 && k[0]) ? 32'h0 : rand_word(), rand_word(),
                       alu_op_t'($unsigned($random(seed)) % 10), 1'(rand_word()),
                       result_sel_t'(rand_word() & 3), kind == 1, kind == 2, kind == 3,
                       funct3_t'(rand_word() & 7), (kind != 0) ? 1'(rand_word()) : 1'b0);
        end
        wait_drained("stream");

        $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
                 checks, errors, timeouts, u_riscv_exec.u_riscv_exec_asserts.fail_cnt);
        if (errors == 0 && timeouts == 0 && u_riscv_exec.u_riscv_exec_asserts.fail_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== riscv_exec.f ====
src/exec_pkg.sv
src/exec_if.sv
src/alu_unit.sv
src/branch_unit.sv
src/redirect_ctrl.sv
src/riscv_exec.sv
testbench/riscv_exec_asserts.sv
testbench/tb_riscv_exec.sv

// ==== Bender.yml ====
package:
  name: riscv_exec

sources:
  # RTL in compile order
  - files:
      - src/exec_pkg.sv
      - src/exec_if.sv
      - src/alu_unit.sv
      - src/branch_unit.sv
      - src/redirect_ctrl.sv
      - src/riscv_exec.sv

  # testbench and bound assertions
  - target: test
    files:
      - testbench/riscv_exec_asserts.sv
      - testbench/tb_riscv_exec.sv
